// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -sv -f files.f \
		--top-module fabric_tb -Mdir obj_dir -o Vfabric_tb

run: compile
	@out="$$(./obj_dir/Vfabric_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir

// File: files.f
hw/mem_msg_pkg.sv
hw/mem_map_pkg.sv
hw/mem_link_if.sv
hw/two_fifo.sv
hw/cmd_router.sv
hw/resp_router.sv
hw/clint_slice.sv
hw/cfg_regs.sv
hw/unicore_mem_fabric.sv
verification/fabric_sva.sv
verification/fabric_tb.sv

// File: hw/cfg_regs.sv
`timescale 1ns/1ps

module cfg_regs
  (  input               clk_i
   , input               reset_i

   , mem_link_if.device  link

   , output logic        freeze_o
   );

  import mem_msg_pkg::*;
  import mem_map_pkg::*;

  logic                  freeze_r;
  logic [data_width-1:0] core_id_r;
  logic [data_width-1:0] scratch_r;
  mem_resp_s             resp_r;
  logic                  resp_v_r;
  logic                  cmd_fire;
  logic                  resp_fire;
  logic                  is_store;
  logic                  hit_dev;
  logic [dev_lsb-1:0]    offset;
  logic [data_width-1:0] rdata;

  assign link.cmd_ready = ~resp_v_r;
  assign cmd_fire       = link.cmd_v & link.cmd_ready;
  assign resp_fire      = link.resp_v & link.resp_ready;
  assign is_store       = (link.cmd.op == store);
  assign offset         = link.cmd.addr[dev_lsb-1:0];
  // Anything else routed here is unclaimed space
  assign hit_dev        = (link.cmd.addr[dev_lsb+:dev_width] == dev_cfg);

  always_comb
  begin
    rdata = '0;
    if (hit_dev)
    begin
      case (offset)
        cfg_freeze_offset:  rdata = data_width'(freeze_r);
        cfg_core_id_offset: rdata = core_id_r;
        cfg_scratch_offset: rdata = scratch_r;
        default:            rdata = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      freeze_r  <= 1'b1;
      core_id_r <= '0;
      scratch_r <= '0;
      resp_v_r  <= 1'b0;
    end
    else
    begin
      if (cmd_fire & is_store & hit_dev)
      begin
        case (offset)
          cfg_freeze_offset:  freeze_r  <= link.cmd.data[0];
          cfg_core_id_offset: core_id_r <= link.cmd.data;
          cfg_scratch_offset: scratch_r <= link.cmd.data;
          default:            ;
        endcase
      end
      if (cmd_fire)
        resp_v_r <= 1'b1;
      else if (resp_fire)
        resp_v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_fire)
    begin
      resp_r.op     <= link.cmd.op;
      resp_r.addr   <= link.cmd.addr;
      resp_r.data   <= is_store ? '0 : rdata;
      resp_r.src_id <= link.cmd.src_id;
    end
  end

  assign link.resp   = resp_r;
  assign link.resp_v = resp_v_r;
  assign freeze_o    = freeze_r;

endmodule

// File: hw/clint_slice.sv
`timescale 1ns/1ps

module clint_slice
  (  input               clk_i
   , input               reset_i

   , mem_link_if.device  link

   , output logic        timer_irq_o
   , output logic        software_irq_o
   );

  import mem_msg_pkg::*;
  import mem_map_pkg::*;

  logic [data_width-1:0] mtime_r;
  logic [data_width-1:0] mtimecmp_r;
  logic                  msip_r;
  mem_resp_s             resp_r;
  logic                  resp_v_r;
  logic                  cmd_fire;
  logic                  resp_fire;
  logic                  is_store;
  logic [dev_lsb-1:0]    offset;
  logic [data_width-1:0] rdata;

  // One command in flight at a time
  assign link.cmd_ready = ~resp_v_r;
  assign cmd_fire       = link.cmd_v & link.cmd_ready;
  assign resp_fire      = link.resp_v & link.resp_ready;
  assign offset         = link.cmd.addr[dev_lsb-1:0];
  assign is_store       = (link.cmd.op == store);

  always_comb
  begin
    case (offset)
      clint_msip_offset:     rdata = data_width'(msip_r);
      clint_mtimecmp_offset: rdata = mtimecmp_r;
      clint_mtime_offset:    rdata = mtime_r;
      default:               rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      mtime_r    <= '0;
      mtimecmp_r <= '1;
      msip_r     <= 1'b0;
    end
    else
    begin
      mtime_r <= mtime_r + 1'b1;
      // A store to mtime overrides the increment
      if (cmd_fire & is_store)
      begin
        case (offset)
          clint_msip_offset:     msip_r     <= link.cmd.data[0];
          clint_mtimecmp_offset: mtimecmp_r <= link.cmd.data;
          clint_mtime_offset:    mtime_r    <= link.cmd.data;
          default:               ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      resp_v_r <= 1'b0;
    else if (cmd_fire)
      resp_v_r <= 1'b1;
    else if (resp_fire)
      resp_v_r <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_fire)
    begin
      resp_r.op     <= link.cmd.op;
      resp_r.addr   <= link.cmd.addr;
      resp_r.data   <= is_store ? '0 : rdata;
      resp_r.src_id <= link.cmd.src_id;
    end
  end

  assign link.resp   = resp_r;
  assign link.resp_v = resp_v_r;

  assign timer_irq_o    = (mtime_r >= mtimecmp_r);
  assign software_irq_o = msip_r;

endmodule

// File: hw/cmd_router.sv
`timescale 1ns/1ps

module cmd_router
  (  input mem_msg_pkg::mem_cmd_s             src_cmd_i [mem_msg_pkg::num_src]
   , input        [mem_msg_pkg::num_src-1:0]  src_cmd_v_i
   , output logic [mem_msg_pkg::num_src-1:0]  src_cmd_yumi_o

   , mem_link_if.dispatch                     cfg_link
   , mem_link_if.dispatch                     clint_link
   , mem_link_if.dispatch                     io_link
   , mem_link_if.dispatch                     dram_link
   );

  import mem_msg_pkg::*;
  import mem_map_pkg::*;

  logic                 all_ready;
  mem_cmd_s             sel_cmd;
  logic                 sel_v;
  logic                 is_local;
  logic [dev_width-1:0] dev;
  logic                 to_dram;
  logic                 to_io;
  logic                 to_clint;
  logic                 to_cfg;

  // One stalled destination holds every source
  assign all_ready = cfg_link.cmd_ready & clint_link.cmd_ready
                   & io_link.cmd_ready & dram_link.cmd_ready;

  // Higher source index wins
  always_comb
  begin
    src_cmd_yumi_o = '0;
    sel_cmd        = src_cmd_i[0];
    for (int i = 0; i < num_src; i++)
    begin
      if (src_cmd_v_i[i])
      begin
        src_cmd_yumi_o    = '0;
        src_cmd_yumi_o[i] = all_ready;
        sel_cmd           = src_cmd_i[i];
      end
    end
  end

  assign sel_v = |src_cmd_yumi_o;

  assign is_local = (sel_cmd.addr < dram_base_addr);
  assign dev      = sel_cmd.addr[dev_lsb+:dev_width];
  assign to_dram  = ~is_local;
  assign to_io    = is_local & ((dev == dev_boot) | (dev == dev_host));
  assign to_clint = is_local & (dev == dev_clint);
  // Unclaimed local space lands in the config block
  assign to_cfg   = is_local & ~to_io & ~to_clint;

  assign cfg_link.cmd   = sel_cmd;
  assign clint_link.cmd = sel_cmd;
  assign io_link.cmd    = sel_cmd;
  assign dram_link.cmd  = sel_cmd;

  assign cfg_link.cmd_v   = sel_v & to_cfg;
  assign clint_link.cmd_v = sel_v & to_clint;
  assign io_link.cmd_v    = sel_v & to_io;
  assign dram_link.cmd_v  = sel_v & to_dram;

endmodule

// File: hw/mem_link_if.sv
`timescale 1ns/1ps

interface mem_link_if;

  import mem_msg_pkg::*;

  mem_cmd_s  cmd;
  logic      cmd_v;
  logic      cmd_ready;

  mem_resp_s resp;
  logic      resp_v;
  logic      resp_ready;

  // Command side of the command router
  modport dispatch (output cmd, output cmd_v, input cmd_ready);

  // Response side of the response router
  modport collect (input resp, input resp_v, output resp_ready);

  modport device
  (  input  cmd
   , input  cmd_v
   , output cmd_ready
   , output resp
   , output resp_v
   , input  resp_ready
   );

endinterface

// File: hw/mem_map_pkg.sv
package mem_map_pkg;

  // Everything below this is local space
  localparam logic [31:0] dram_base_addr = 32'h8000_0000;

  localparam int dev_lsb   = 20;
  localparam int dev_width = 4;

  localparam logic [dev_width-1:0] dev_boot  = 4'd0;
  localparam logic [dev_width-1:0] dev_host  = 4'd1;
  localparam logic [dev_width-1:0] dev_cfg   = 4'd2;
  localparam logic [dev_width-1:0] dev_clint = 4'd3;

  // Offsets cover the address bits below the device field
  localparam logic [dev_lsb-1:0] clint_msip_offset     = 20'h0_0000;
  localparam logic [dev_lsb-1:0] clint_mtimecmp_offset = 20'h0_4000;
  localparam logic [dev_lsb-1:0] clint_mtime_offset    = 20'h0_bff8;

  localparam logic [dev_lsb-1:0] cfg_freeze_offset  = 20'h0_0000;
  localparam logic [dev_lsb-1:0] cfg_core_id_offset = 20'h0_0008;
  localparam logic [dev_lsb-1:0] cfg_scratch_offset = 20'h0_0010;

endpackage

// File: hw/mem_msg_pkg.sv
package mem_msg_pkg;

  localparam int paddr_width = 32;
  localparam int data_width  = 64;
  localparam int num_src     = 3;

  // Requester index: 0 fetch, 1 data, 2 incoming I/O
  typedef logic [1:0] src_id_t;

  typedef enum logic
  {
    load  = 1'b0,
    store = 1'b1
  } mem_op_e;

  typedef struct packed
  {
    mem_op_e                op;
    logic [paddr_width-1:0] addr;
    logic [data_width-1:0]  data;
    src_id_t                src_id;
  } mem_cmd_s;

  // Load data in data, zero for stores
  typedef struct packed
  {
    mem_op_e                op;
    logic [paddr_width-1:0] addr;
    logic [data_width-1:0]  data;
    src_id_t                src_id;
  } mem_resp_s;

endpackage

// File: hw/resp_router.sv
`timescale 1ns/1ps

module resp_router
  (  mem_link_if.collect                      cfg_link
   , mem_link_if.collect                      clint_link
   , mem_link_if.collect                      io_link
   , mem_link_if.collect                      dram_link

   , output mem_msg_pkg::mem_resp_s           dst_resp_o
   , output logic [mem_msg_pkg::num_src-1:0]  dst_resp_v_o
   , input        [mem_msg_pkg::num_src-1:0]  dst_ready_i
   );

  import mem_msg_pkg::*;

  logic all_ready;
  logic grant_v;

  // Only move a response when every return FIFO has room
  assign all_ready = &dst_ready_i;

  always_comb
  begin
    dram_link.resp_ready  = 1'b0;
    io_link.resp_ready    = 1'b0;
    clint_link.resp_ready = 1'b0;
    cfg_link.resp_ready   = 1'b0;
    dst_resp_o            = cfg_link.resp;
    grant_v               = 1'b0;
    if (dram_link.resp_v)
    begin
      dram_link.resp_ready = all_ready;
      dst_resp_o           = dram_link.resp;
      grant_v              = 1'b1;
    end
    else if (io_link.resp_v)
    begin
      io_link.resp_ready = all_ready;
      dst_resp_o         = io_link.resp;
      grant_v            = 1'b1;
    end
    else if (clint_link.resp_v)
    begin
      clint_link.resp_ready = all_ready;
      dst_resp_o            = clint_link.resp;
      grant_v               = 1'b1;
    end
    else if (cfg_link.resp_v)
    begin
      cfg_link.resp_ready = all_ready;
      dst_resp_o          = cfg_link.resp;
      grant_v             = 1'b1;
    end
  end

  for (genvar i = 0; i < num_src; i++)
  begin : ret
    assign dst_resp_v_o[i] = grant_v & all_ready & (dst_resp_o.src_id == src_id_t'(i));
  end

endmodule

// File: hw/two_fifo.sv
`timescale 1ns/1ps

module two_fifo
  #(parameter type payload_t = logic)
  (  input                  clk_i
   , input                  reset_i

   , input  payload_t       data_i
   , input                  v_i
   , output logic           ready_o

   , output payload_t       data_o
   , output logic           v_o
   , input                  yumi_i
   );

  payload_t   mem_r [2];
  logic       rptr_r;
  logic       wptr_r;
  logic [1:0] count_r;
  logic       enq;
  logic       deq;

  assign ready_o = (count_r != 2'd2);
  assign v_o     = (count_r != 2'd0);
  assign data_o  = mem_r[rptr_r];

  assign enq = v_i & ready_o;
  assign deq = yumi_i & v_o;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      rptr_r  <= 1'b0;
      wptr_r  <= 1'b0;
      count_r <= 2'd0;
    end
    else
    begin
      if (enq)
        wptr_r <= ~wptr_r;
      if (deq)
        rptr_r <= ~rptr_r;
      count_r <= count_r + 2'(enq) - 2'(deq);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (enq)
      mem_r[wptr_r] <= data_i;
  end

endmodule

// File: hw/unicore_mem_fabric.sv
`timescale 1ns/1ps

module unicore_mem_fabric
  (  input                                clk_i
   , input                                reset_i

   // Instruction fetch, source 0
   , input  mem_msg_pkg::mem_cmd_s        fetch_cmd_i
   , input                                fetch_cmd_v_i
   , output logic                         fetch_cmd_ready_o
   , output mem_msg_pkg::mem_resp_s       fetch_resp_o
   , output logic                         fetch_resp_v_o
   , input                                fetch_resp_ready_i

   // Data access, source 1
   , input  mem_msg_pkg::mem_cmd_s        data_cmd_i
   , input                                data_cmd_v_i
   , output logic                         data_cmd_ready_o
   , output mem_msg_pkg::mem_resp_s       data_resp_o
   , output logic                         data_resp_v_o
   , input                                data_resp_ready_i

   // Incoming I/O, source 2
   , input  mem_msg_pkg::mem_cmd_s        io_in_cmd_i
   , input                                io_in_cmd_v_i
   , output logic                         io_in_cmd_ready_o
   , output mem_msg_pkg::mem_resp_s       io_in_resp_o
   , output logic                         io_in_resp_v_o
   , input                                io_in_resp_ready_i

   // Outgoing I/O
   , output mem_msg_pkg::mem_cmd_s        io_out_cmd_o
   , output logic                         io_out_cmd_v_o
   , input                                io_out_cmd_ready_i
   , input  mem_msg_pkg::mem_resp_s       io_out_resp_i
   , input                                io_out_resp_v_i
   , output logic                         io_out_resp_ready_o

   , output mem_msg_pkg::mem_cmd_s        dram_cmd_o
   , output logic                         dram_cmd_v_o
   , input                                dram_cmd_ready_i
   , input  mem_msg_pkg::mem_resp_s       dram_resp_i
   , input                                dram_resp_v_i
   , output logic                         dram_resp_ready_o

   , output logic                         timer_irq_o
   , output logic                         software_irq_o
   , output logic                         freeze_o
   );

  import mem_msg_pkg::*;

  mem_cmd_s           src_cmd [num_src];
  logic [num_src-1:0] src_cmd_v;
  logic [num_src-1:0] src_cmd_ready;
  mem_resp_s          src_resp [num_src];
  logic [num_src-1:0] src_resp_v;
  logic [num_src-1:0] src_resp_ready;

  mem_cmd_s           cmd_fifo_data [num_src];
  logic [num_src-1:0] cmd_fifo_v;
  logic [num_src-1:0] cmd_fifo_yumi;
  mem_resp_s          ret_resp;
  logic [num_src-1:0] ret_resp_v;
  logic [num_src-1:0] resp_fifo_ready;

  assign src_cmd[0] = fetch_cmd_i;
  assign src_cmd[1] = data_cmd_i;
  assign src_cmd[2] = io_in_cmd_i;
  assign src_cmd_v  = {io_in_cmd_v_i, data_cmd_v_i, fetch_cmd_v_i};
  assign {io_in_cmd_ready_o, data_cmd_ready_o, fetch_cmd_ready_o} = src_cmd_ready;

  assign fetch_resp_o   = src_resp[0];
  assign data_resp_o    = src_resp[1];
  assign io_in_resp_o   = src_resp[2];
  assign {io_in_resp_v_o, data_resp_v_o, fetch_resp_v_o} = src_resp_v;
  assign src_resp_ready = {io_in_resp_ready_i, data_resp_ready_i, fetch_resp_ready_i};

  for (genvar i = 0; i < num_src; i++)
  begin : src
    two_fifo #(.payload_t(mem_cmd_s)) cmd_fifo
      (.clk_i(clk_i)
       ,.reset_i(reset_i)
       ,.data_i(src_cmd[i])
       ,.v_i(src_cmd_v[i])
       ,.ready_o(src_cmd_ready[i])
       ,.data_o(cmd_fifo_data[i])
       ,.v_o(cmd_fifo_v[i])
       ,.yumi_i(cmd_fifo_yumi[i])
       );

    two_fifo #(.payload_t(mem_resp_s)) resp_fifo
      (.clk_i(clk_i)
       ,.reset_i(reset_i)
       ,.data_i(ret_resp)
       ,.v_i(ret_resp_v[i])
       ,.ready_o(resp_fifo_ready[i])
       ,.data_o(src_resp[i])
       ,.v_o(src_resp_v[i])
       ,.yumi_i(src_resp_v[i] & src_resp_ready[i])
       );
  end

  mem_link_if cfg_link ();
  mem_link_if clint_link ();
  mem_link_if io_link ();
  mem_link_if dram_link ();

  cmd_router cmd_rtr
    (.src_cmd_i(cmd_fifo_data)
     ,.src_cmd_v_i(cmd_fifo_v)
     ,.src_cmd_yumi_o(cmd_fifo_yumi)
     ,.cfg_link(cfg_link.dispatch)
     ,.clint_link(clint_link.dispatch)
     ,.io_link(io_link.dispatch)
     ,.dram_link(dram_link.dispatch)
     );

  resp_router resp_rtr
    (.cfg_link(cfg_link.collect)
     ,.clint_link(clint_link.collect)
     ,.io_link(io_link.collect)
     ,.dram_link(dram_link.collect)
     ,.dst_resp_o(ret_resp)
     ,.dst_resp_v_o(ret_resp_v)
     ,.dst_ready_i(resp_fifo_ready)
     );

  clint_slice clint
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.link(clint_link.device)
     ,.timer_irq_o(timer_irq_o)
     ,.software_irq_o(software_irq_o)
     );

  cfg_regs cfg
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.link(cfg_link.device)
     ,.freeze_o(freeze_o)
     );

  // External destinations face the top-level ports directly
  assign io_out_cmd_o        = io_link.cmd;
  assign io_out_cmd_v_o      = io_link.cmd_v;
  assign io_link.cmd_ready   = io_out_cmd_ready_i;
  assign io_link.resp        = io_out_resp_i;
  assign io_link.resp_v      = io_out_resp_v_i;
  assign io_out_resp_ready_o = io_link.resp_ready;

  assign dram_cmd_o          = dram_link.cmd;
  assign dram_cmd_v_o        = dram_link.cmd_v;
  assign dram_link.cmd_ready = dram_cmd_ready_i;
  assign dram_link.resp      = dram_resp_i;
  assign dram_link.resp_v    = dram_resp_v_i;
  assign dram_resp_ready_o   = dram_link.resp_ready;

endmodule

// File: verification/fabric_sva.sv
`timescale 1ns/1ps

module fabric_sva
  (  input                           clk_i
   , input                           reset_i
   , input  mem_msg_pkg::mem_cmd_s   dram_cmd_o
   , input                           dram_cmd_v_o
   , input                           dram_cmd_ready_i
   , input  mem_msg_pkg::mem_cmd_s   io_out_cmd_o
   , input                           io_out_cmd_v_o
   , input                           io_out_cmd_ready_i
   , input  mem_msg_pkg::mem_resp_s  fetch_resp_o
   , input                           fetch_resp_v_o
   , input                           fetch_resp_ready_i
   , input  mem_msg_pkg::mem_resp_s  data_resp_o
   , input                           data_resp_v_o
   , input                           data_resp_ready_i
   , input  mem_msg_pkg::mem_resp_s  io_in_resp_o
   , input                           io_in_resp_v_o
   , input                           io_in_resp_ready_i
   , input                           timer_irq_o
   , input                           software_irq_o
   , input                           cfg_cmd_v
   , input                           clint_cmd_v
   );

  // Valid outputs hold with stable data until taken
  a_dram_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    dram_cmd_v_o && !dram_cmd_ready_i |=> dram_cmd_v_o && $stable(dram_cmd_o))
    else $error("dram command dropped or changed before transfer");
  a_io_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    io_out_cmd_v_o && !io_out_cmd_ready_i |=> io_out_cmd_v_o && $stable(io_out_cmd_o))
    else $error("io_out command dropped or changed before transfer");
  a_fetch_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    fetch_resp_v_o && !fetch_resp_ready_i |=> fetch_resp_v_o && $stable(fetch_resp_o))
    else $error("fetch response dropped or changed before transfer");
  a_data_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    data_resp_v_o && !data_resp_ready_i |=> data_resp_v_o && $stable(data_resp_o))
    else $error("data response dropped or changed before transfer");
  a_io_in_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    io_in_resp_v_o && !io_in_resp_ready_i |=> io_in_resp_v_o && $stable(io_in_resp_o))
    else $error("io_in response dropped or changed before transfer");

  a_irq_reset: assert property (@(posedge clk_i)
    reset_i |=> !timer_irq_o && !software_irq_o)
    else $error("interrupt output high during reset");

  a_one_dest: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0({cfg_cmd_v, clint_cmd_v, io_out_cmd_v_o, dram_cmd_v_o}))
    else $error("more than one destination command valid");

endmodule

// File: verification/fabric_tb.sv
`timescale 1ns/1ps

module fabric_tb;

  import mem_msg_pkg::*;

  localparam int num_rows  = 15;
  localparam int dst_dram  = 0;
  localparam int dst_io    = 1;
  localparam int dst_clint = 2;
  localparam int dst_cfg   = 3;
  // Table rows plus about ten commands in the CLINT, return and stall sequences
  localparam int cycle_limit = (num_rows + 10) * 40 + 200;

  typedef struct
  {
    int          src;
    mem_op_e     op;
    logic [31:0] addr;
    logic [63:0] data;
    int          dest;
    logic [63:0] exp;
  } row_t;

  logic clk_i;
  logic reset_i;
  mem_cmd_s           src_cmd [num_src];
  logic [num_src-1:0] src_cmd_v;
  logic [num_src-1:0] src_cmd_ready;
  mem_resp_s          src_resp [num_src];
  logic [num_src-1:0] src_resp_v;
  logic [num_src-1:0] src_resp_ready;
  mem_cmd_s  io_out_cmd_o, dram_cmd_o;
  logic      io_out_cmd_v_o, dram_cmd_v_o, io_out_cmd_ready_i, dram_cmd_ready_i;
  mem_resp_s io_out_resp_i, dram_resp_i;
  logic      io_out_resp_v_i, dram_resp_v_i, io_out_resp_ready_o, dram_resp_ready_o;
  logic      timer_irq_o, software_irq_o, freeze_o;

  row_t      rows [num_rows];
  mem_cmd_s  dram_log[$], io_log[$], dram_pend[$], io_pend[$];
  mem_resp_s resp_log[$];
  int        resp_port[$];
  int        dram_pops, io_pops, dram_seen, io_seen, dram_delay, io_delay;
  int        cycle, errors;
  logic      stall_dram;
  integer    seed;

  unicore_mem_fabric dut_i
    (.clk_i(clk_i), .reset_i(reset_i)
     ,.fetch_cmd_i(src_cmd[0]), .fetch_cmd_v_i(src_cmd_v[0])
     ,.fetch_cmd_ready_o(src_cmd_ready[0]), .fetch_resp_o(src_resp[0])
     ,.fetch_resp_v_o(src_resp_v[0]), .fetch_resp_ready_i(src_resp_ready[0])
     ,.data_cmd_i(src_cmd[1]), .data_cmd_v_i(src_cmd_v[1])
     ,.data_cmd_ready_o(src_cmd_ready[1]), .data_resp_o(src_resp[1])
     ,.data_resp_v_o(src_resp_v[1]), .data_resp_ready_i(src_resp_ready[1])
     ,.io_in_cmd_i(src_cmd[2]), .io_in_cmd_v_i(src_cmd_v[2])
     ,.io_in_cmd_ready_o(src_cmd_ready[2]), .io_in_resp_o(src_resp[2])
     ,.io_in_resp_v_o(src_resp_v[2]), .io_in_resp_ready_i(src_resp_ready[2])
     ,.io_out_cmd_o(io_out_cmd_o), .io_out_cmd_v_o(io_out_cmd_v_o)
     ,.io_out_cmd_ready_i(io_out_cmd_ready_i), .io_out_resp_i(io_out_resp_i)
     ,.io_out_resp_v_i(io_out_resp_v_i), .io_out_resp_ready_o(io_out_resp_ready_o)
     ,.dram_cmd_o(dram_cmd_o), .dram_cmd_v_o(dram_cmd_v_o)
     ,.dram_cmd_ready_i(dram_cmd_ready_i), .dram_resp_i(dram_resp_i)
     ,.dram_resp_v_i(dram_resp_v_i), .dram_resp_ready_o(dram_resp_ready_o)
     ,.timer_irq_o(timer_irq_o), .software_irq_o(software_irq_o), .freeze_o(freeze_o)
     );

  bind unicore_mem_fabric fabric_sva sva_i
    (.*, .cfg_cmd_v(cfg_link.cmd_v), .clint_cmd_v(clint_link.cmd_v));

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;

  // External responders answer loads with the address XOR A5A5
  function automatic mem_resp_s reply(mem_cmd_s c);
    mem_resp_s r;
    r.op     = c.op;
    r.addr   = c.addr;
    r.data   = (c.op == load) ? (64'(c.addr) ^ 64'hA5A5) : 64'h0;
    r.src_id = c.src_id;
    return r;
  endfunction

  function automatic mem_cmd_s make_cmd(int s, mem_op_e op, logic [31:0] a, logic [63:0] d);
    mem_cmd_s c;
    c.op     = op;
    c.addr   = a;
    c.data   = d;
    c.src_id = src_id_t'(s);
    return c;
  endfunction

  task automatic report_mismatch(string what, logic [127:0] got, logic [127:0] exp);
    errors++;
    $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
  endtask

  task automatic report_problem(string what);
    errors++;
    $display("error at %0t: %s", $time, what);
  endtask

  always @(negedge clk_i)
  begin
    if (reset_i)
    begin
      dram_resp_v_i = 1'b0;
      io_out_resp_v_i = 1'b0;
    end
    else
    begin
      if (dram_pops != dram_seen)
      begin
        dram_seen  = dram_pops;
        dram_delay = int'($unsigned($random(seed)) % 4);
      end
      if (io_pops != io_seen)
      begin
        io_seen  = io_pops;
        io_delay = int'($unsigned($random(seed)) % 4);
      end
      dram_resp_v_i = (dram_pend.size() > 0) && (dram_delay == 0);
      if (dram_resp_v_i)
        dram_resp_i = reply(dram_pend[0]);
      else if (dram_delay > 0)
        dram_delay--;
      io_out_resp_v_i = (io_pend.size() > 0) && (io_delay == 0);
      if (io_out_resp_v_i)
        io_out_resp_i = reply(io_pend[0]);
      else if (io_delay > 0)
        io_delay--;
      dram_cmd_ready_i   = !stall_dram && ($random(seed) % 4 != 0);
      io_out_cmd_ready_i = ($random(seed) % 3 != 0);
      // Sources sometimes hold off their responses
      for (int s = 0; s < num_src; s++)
        src_resp_ready[s] = ($random(seed) % 4 != 0);
    end
  end

  // Transfers are logged at the clock edge where they happen
  always @(posedge clk_i)
  begin
    cycle++;
    if (cycle >= cycle_limit)
    begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("tests failed");
      $finish;
    end
    else if (!reset_i)
    begin
      if (dram_cmd_v_o && dram_cmd_ready_i)
      begin
        dram_log.push_back(dram_cmd_o);
        dram_pend.push_back(dram_cmd_o);
      end
      if (io_out_cmd_v_o && io_out_cmd_ready_i)
      begin
        io_log.push_back(io_out_cmd_o);
        io_pend.push_back(io_out_cmd_o);
      end
      if (dram_resp_v_i && dram_resp_ready_o)
      begin
        void'(dram_pend.pop_front());
        dram_pops++;
      end
      if (io_out_resp_v_i && io_out_resp_ready_o)
      begin
        void'(io_pend.pop_front());
        io_pops++;
      end
      for (int s = 0; s < num_src; s++)
      begin
        if (src_resp_v[s] && src_resp_ready[s])
        begin
          resp_log.push_back(src_resp[s]);
          resp_port.push_back(s);
        end
      end
    end
  end

  task automatic send_cmd(int s, mem_cmd_s c);
    @(negedge clk_i);
    src_cmd[s]   = c;
    src_cmd_v[s] = 1'b1;
    @(posedge clk_i);
    while (!src_cmd_ready[s])
      @(posedge clk_i);
    @(negedge clk_i);
    src_cmd_v[s] = 1'b0;
  endtask

  task automatic wait_resps(int n);
    while (resp_log.size() < n)
      @(posedge clk_i);
  endtask

  task automatic clear_logs();
    dram_log.delete();
    io_log.delete();
    resp_log.delete();
    resp_port.delete();
  endtask

  // One command, one response on the issuing port
  task automatic run_op(mem_cmd_s c, output mem_resp_s r);
    clear_logs();
    send_cmd(int'(c.src_id), c);
    wait_resps(1);
    r = resp_log[0];
    if (resp_port[0] != int'(c.src_id))
      report_problem($sformatf("response for source %0d on port %0d", c.src_id, resp_port[0]));
    if (r.addr !== c.addr)
      report_mismatch("response address", 128'(r.addr), 128'(c.addr));
  endtask

  task automatic fill_table();
    rows[0]  = '{0, load,  32'h8000_1000, 64'h0, dst_dram, 64'h8000_b5a5};
    rows[1]  = '{1, store, 32'h8000_2008, 64'h1234, dst_dram, 64'h0};
    rows[2]  = '{2, load,  32'h0000_0040, 64'h0, dst_io, 64'ha5e5};
    rows[3]  = '{1, load,  32'h0010_0100, 64'h0, dst_io, 64'h0010_a4a5};
    rows[4]  = '{1, load,  32'h0020_0000, 64'h0, dst_cfg, 64'h1};
    rows[5]  = '{1, store, 32'h0020_0000, 64'h0, dst_cfg, 64'h0};
    rows[6]  = '{0, store, 32'h0020_0008, 64'h7, dst_cfg, 64'h0};
    rows[7]  = '{0, load,  32'h0020_0008, 64'h0, dst_cfg, 64'h7};
    rows[8]  = '{2, store, 32'h0020_0010, 64'hdead_beef_cafe_f00d, dst_cfg, 64'h0};
    rows[9]  = '{1, load,  32'h0020_0010, 64'h0, dst_cfg, 64'hdead_beef_cafe_f00d};
    // Unclaimed local space reads zero and drops stores
    rows[10] = '{1, load,  32'h0050_0010, 64'h0, dst_cfg, 64'h0};
    rows[11] = '{2, store, 32'h0070_0010, 64'hff, dst_cfg, 64'h0};
    rows[12] = '{2, load,  32'h0020_0010, 64'h0, dst_cfg, 64'hdead_beef_cafe_f00d};
    rows[13] = '{1, store, 32'h0030_0000, 64'h1, dst_clint, 64'h0};
    rows[14] = '{1, load,  32'h0030_0000, 64'h0, dst_clint, 64'h1};
  endtask

  initial
  begin
    mem_cmd_s    c;
    mem_resp_s   r;
    logic [63:0] t1;
    logic [63:0] t2;
    mem_cmd_s    order [4];
    logic [63:0] ret_exp [num_src];

    seed = 32'h839c_1307;
    errors = 0;
    cycle = 0;
    stall_dram = 1'b0;
    dram_pops = 0;
    io_pops = 0;
    dram_seen = 0;
    io_seen = 0;
    dram_delay = 0;
    io_delay = 0;
    src_cmd_v = '0;
    src_resp_ready = '0;
    for (int s = 0; s < num_src; s++)
      src_cmd[s] = '0;
    dram_cmd_ready_i = 1'b0;
    io_out_cmd_ready_i = 1'b0;
    dram_resp_i = '0;
    io_out_resp_i = '0;
    dram_resp_v_i = 1'b0;
    io_out_resp_v_i = 1'b0;
    reset_i = 1'b1;
    fill_table();
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    if (freeze_o !== 1'b1)
      report_mismatch("freeze after reset", 128'(freeze_o), 128'(1));
    if (timer_irq_o !== 1'b0)
      report_mismatch("timer irq after reset", 128'(timer_irq_o), 128'(0));

    for (int i = 0; i < num_rows; i++)
    begin
      c = make_cmd(rows[i].src, rows[i].op, rows[i].addr, rows[i].data);
      run_op(c, r);
      if (r.data !== rows[i].exp)
        report_mismatch($sformatf("row %0d data", i), 128'(r.data), 128'(rows[i].exp));
      if (rows[i].dest == dst_dram)
      begin
        if (dram_log.size() != 1 || io_log.size() != 0)
          report_problem($sformatf("row %0d not seen once on the dram port only", i));
        else if (dram_log[0] !== c)
          report_mismatch($sformatf("row %0d dram command", i), 128'(dram_log[0]), 128'(c));
      end
      else if (rows[i].dest == dst_io)
      begin
        if (io_log.size() != 1 || dram_log.size() != 0)
          report_problem($sformatf("row %0d not seen once on the io_out port only", i));
        else if (io_log[0] !== c)
          report_mismatch($sformatf("row %0d io_out command", i), 128'(io_log[0]), 128'(c));
      end
      else if (dram_log.size() + io_log.size() != 0)
        report_problem($sformatf("row %0d leaked to an external port", i));
    end
    if (freeze_o !== 1'b0)
      report_mismatch("freeze after clear", 128'(freeze_o), 128'(0));
    if (software_irq_o !== 1'b1)
      report_mismatch("software irq", 128'(software_irq_o), 128'(1));

    // Timer runs forward, and a compare below it fires the interrupt
    run_op(make_cmd(1, load, 32'h0030_bff8, 64'h0), r);
    t1 = r.data;
    run_op(make_cmd(1, load, 32'h0030_bff8, 64'h0), r);
    t2 = r.data;
    if (!(t2 > t1))
      report_mismatch("second mtime read", 128'(t2), 128'(t1 + 64'h1));
    run_op(make_cmd(1, store, 32'h0030_4000, t2 - 64'd5), r);
    @(negedge clk_i);
    if (timer_irq_o !== 1'b1)
      report_mismatch("timer irq", 128'(timer_irq_o), 128'(1));

    // All three sources at once
    clear_logs();
    ret_exp[0] = 64'h8000_a1a5;
    ret_exp[1] = 64'hdead_beef_cafe_f00d;
    ret_exp[2] = 64'ha525;
    @(negedge clk_i);
    src_cmd[0] = make_cmd(0, load, 32'h8000_0400, 64'h0);
    src_cmd[1] = make_cmd(1, load, 32'h0020_0010, 64'h0);
    src_cmd[2] = make_cmd(2, load, 32'h0000_0080, 64'h0);
    src_cmd_v = '1;
    @(negedge clk_i);
    src_cmd_v = '0;
    wait_resps(3);
    for (int i = 0; i < 3; i++)
    begin
      if (resp_port[i] != int'(resp_log[i].src_id))
        report_problem($sformatf("response for source %0d on port %0d",
                                 resp_log[i].src_id, resp_port[i]));
      else if (resp_log[i].data !== ret_exp[resp_port[i]])
        report_mismatch($sformatf("port %0d return data", resp_port[i]),
                        128'(resp_log[i].data), 128'(ret_exp[resp_port[i]]));
    end

    // DRAM stall fills the data FIFO, then release drains by priority
    stall_dram = 1'b1;
    repeat (2) @(negedge clk_i);
    clear_logs();
    order[1] = make_cmd(1, load, 32'h8000_0010, 64'h0);
    order[2] = make_cmd(1, load, 32'h8000_0020, 64'h0);
    order[0] = make_cmd(2, load, 32'h8000_0030, 64'h0);
    order[3] = make_cmd(0, load, 32'h8000_0040, 64'h0);
    send_cmd(1, order[1]);
    send_cmd(1, order[2]);
    @(negedge clk_i);
    if (src_cmd_ready[1] !== 1'b0)
      report_problem("data command FIFO still ready after two stalled commands");
    send_cmd(2, order[0]);
    send_cmd(0, order[3]);
    stall_dram = 1'b0;
    wait_resps(4);
    for (int i = 0; i < 4; i++)
    begin
      if (dram_log[i] !== order[i])
        report_mismatch($sformatf("dram order slot %0d", i),
                        128'(dram_log[i]), 128'(order[i]));
    end

    $display("error count: %0d", errors);
    if (errors == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule
